// File: x300_radio_io.f
radio_regmap_pkg.sv
radio_io_pkg.sv
db_settings_regs.sv
atr_gpio_select.sv
gpio_out_mux.sv
radio_io_core.sv
radio_io_core_tb.sv

// File: Bender.yml
package:
  name: x300_radio_io

sources:
  # packages first, the register map feeds the io types
  - radio_regmap_pkg.sv
  - radio_io_pkg.sv
  # pipeline stages and top level
  - db_settings_regs.sv
  - atr_gpio_select.sv
  - gpio_out_mux.sv
  - radio_io_core.sv
  # testbench
  - target: test
    files:
      - radio_io_core_tb.sv

// File: radio_io_core_tb.sv
// cycle model of the default two-slot build; the LFSR seed is fixed, so every run drives the same stimulus
`timescale 1ns/10ps
`default_nettype none

module radio_io_core_tb
   import radio_regmap_pkg::*;
   import radio_io_pkg::*;
();

   localparam int NUM_DBOARDS     = 2;
   localparam int CHANNELS_PER_DB = 2;
   localparam int FP_GPIO_WIDTH   = 12;
   localparam int SR_DB_BASE      = 160;
   localparam int RB_DB_BASE      = 16;
   localparam int NCH             = NUM_DBOARDS * CHANNELS_PER_DB;
   localparam int CLK_PERIOD      = 20;
   localparam int RESET_CYCLES    = 4;
   localparam int PHASE_CYCLES    = 300;   // per test phase, three phases
   localparam int TOTAL_CYCLES    = RESET_CYCLES + 3 * PHASE_CYCLES;

   // --------------------
   // DUT signals
   // --------------------
   logic                       radio_clk;
   logic                       rst_n;
   set_bus_t                   set_bus  [NUM_DBOARDS];
   rb_req_t                    rb_req   [NUM_DBOARDS];
   logic [NCH-1:0]             rx_run;
   logic [NCH-1:0]             tx_run;
   gpio_word_t                 db_in    [NUM_DBOARDS];
   gpio_word_t                 fp_in;
   gpio_word_t                 misc_in  [NUM_DBOARDS];
   gpio_word_t                 blk_ctr  [NUM_DBOARDS];
   gpio_bank_t                 blk_bank [NUM_DBOARDS];
   logic [2*FP_GPIO_WIDTH-1:0] fp_src;

   wire gpio_bank_t db_gpio   [NUM_DBOARDS];
   wire gpio_bank_t fp_gpio;
   wire [2:0]       radio_led [NUM_DBOARDS];
   wire gpio_word_t misc_out  [NUM_DBOARDS];
   wire rb_data_t   rb_data   [NUM_DBOARDS];

   // --------------------
   // reference model state
   // --------------------
   gpio_word_t m_atr      [NUM_DBOARDS][4];   // by ATR offset
   gpio_word_t m_ddr      [NUM_DBOARDS];
   gpio_word_t m_fp_out   [NUM_DBOARDS];
   gpio_word_t m_fp_ddr   [NUM_DBOARDS];
   gpio_word_t m_misc_out [NUM_DBOARDS];
   gpio_word_t m_misc_r   [NUM_DBOARDS];
   rb_data_t   m_rb       [NUM_DBOARDS];
   logic       m_rx       [NUM_DBOARDS];      // slot state, rx side
   logic       m_tx       [NUM_DBOARDS];
   gpio_word_t m_bank_out [NUM_DBOARDS];      // selection stage
   gpio_word_t m_bank_ddr [NUM_DBOARDS];
   gpio_word_t m_fpb_out  [NUM_DBOARDS];
   gpio_word_t m_fpb_ddr  [NUM_DBOARDS];
   logic [2:0] m_led      [NUM_DBOARDS];
   gpio_word_t m_db_out   [NUM_DBOARDS];      // pin stage
   gpio_word_t m_db_ddr   [NUM_DBOARDS];
   gpio_word_t m_fp_pin_out;
   gpio_word_t m_fp_pin_ddr;
   logic [31:0] lfsr;

   radio_io_core #(
      .NUM_DBOARDS     (NUM_DBOARDS),
      .CHANNELS_PER_DB (CHANNELS_PER_DB),
      .FP_GPIO_WIDTH   (FP_GPIO_WIDTH),
      .SR_DB_BASE      (SR_DB_BASE),
      .RB_DB_BASE      (RB_DB_BASE)
   ) radio_io_core_inst (
      .radio_clk     (radio_clk),
      .i_rst_n       (rst_n),
      .i_set         (set_bus),
      .i_rb          (rb_req),
      .i_rx_running  (rx_run),
      .i_tx_running  (tx_run),
      .i_db_gpio_in  (db_in),
      .i_fp_gpio_in  (fp_in),
      .i_misc_in     (misc_in),
      .i_blk_ctr     (blk_ctr),
      .i_blk_bank    (blk_bank),
      .i_fp_gpio_src (fp_src),
      .o_db_gpio     (db_gpio),
      .o_fp_gpio     (fp_gpio),
      .o_radio_led   (radio_led),
      .o_misc_out    (misc_out),
      .o_rb_data     (rb_data)
   );

   initial begin
      radio_clk = 1'b0;
      forever #(CLK_PERIOD / 2) radio_clk = ~radio_clk;
   end

   initial begin
      #(CLK_PERIOD * (TOTAL_CYCLES + 50));
      $display("watchdog expired: the test did not finish in the expected number of cycles");
      $display("TEST FAILED");
      $fatal(1, "simulation hung");
   end

   // --------------------
   // random numbers
   // --------------------
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1
      end
      return s >> 1;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr_step(lfsr);
      end
      return v;
   endfunction

   task automatic compare(input string name, input logic [63:0] expected,
                          input logic [63:0] actual);
      if (actual !== expected) begin
         $display("** Error at %0t ns: %s expected 0x%h, actual 0x%h",
                  $time, name, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // --------------------
   // model
   // --------------------
   task automatic model_reset();
      for (int s = 0; s < NUM_DBOARDS; s++) begin
         m_atr[s]      = '{default: '0};
         m_ddr[s]      = '0;
         m_fp_out[s]   = '0;
         m_fp_ddr[s]   = '0;
         m_misc_out[s] = '0;
         m_misc_r[s]   = '0;
         m_rb[s]       = '0;
         m_rx[s]       = 1'b0;
         m_tx[s]       = 1'b0;
         m_bank_out[s] = '0;
         m_bank_ddr[s] = '0;
         m_fpb_out[s]  = '0;
         m_fpb_ddr[s]  = '0;
         m_led[s]      = '0;
         m_db_out[s]   = '0;
         m_db_ddr[s]   = '0;
      end
      m_fp_pin_out = '0;
      m_fp_pin_ddr = '0;
   endtask

   // one rising edge; later stages update first so each reads the old value
   task automatic model_edge();
      int a;
      int sel;
      int idx;
      if (!rst_n) begin
         model_reset();
         return;
      end
      m_fp_pin_out = '0;
      m_fp_pin_ddr = '0;
      for (int p = 0; p < FP_GPIO_WIDTH; p++) begin
         sel = fp_src[2*p +: 2];
         if (sel > NUM_DBOARDS - 1) begin
            sel = NUM_DBOARDS - 1;   // missing slot means the last one
         end
         m_fp_pin_out[p] = m_fpb_out[sel][p];
         m_fp_pin_ddr[p] = m_fpb_ddr[sel][p];
      end
      for (int s = 0; s < NUM_DBOARDS; s++) begin
         for (int b = 0; b < 32; b++) begin
            m_db_out[s][b] = blk_ctr[s][b] ? blk_bank[s].out[b] : m_bank_out[s][b];
            m_db_ddr[s][b] = blk_ctr[s][b] ? blk_bank[s].ddr[b] : m_bank_ddr[s][b];
         end
         idx = m_tx[s] ? (m_rx[s] ? ATR_FDX : ATR_TX) : (m_rx[s] ? ATR_RX : ATR_IDLE);
         m_bank_out[s] = m_atr[s][idx];
         m_bank_ddr[s] = m_ddr[s];
         m_fpb_out[s]  = m_fp_out[s];
         m_fpb_ddr[s]  = m_fp_ddr[s];
         m_led[s]      = {m_rx[s], m_tx[s], m_rx[s] & ~m_tx[s]};
         m_rx[s]       = |rx_run[s*CHANNELS_PER_DB +: CHANNELS_PER_DB];
         m_tx[s]       = |tx_run[s*CHANNELS_PER_DB +: CHANNELS_PER_DB];
         a = set_bus[s].addr;
         if (set_bus[s].stb && a >= SR_DB_BASE && a < SR_DB_BASE + 8) begin
            case (a - SR_DB_BASE)
               ATR_IDLE, ATR_RX, ATR_TX, ATR_FDX : m_atr[s][a - SR_DB_BASE] = set_bus[s].data;
               GPIO_DDR : m_ddr[s]      = set_bus[s].data;
               MISC_OUT : m_misc_out[s] = set_bus[s].data;
               FP_OUT   : m_fp_out[s]   = set_bus[s].data;
               default  : m_fp_ddr[s]   = set_bus[s].data;
            endcase
         end
         a = rb_req[s].addr;
         if (rb_req[s].stb) begin
            if (a == RB_DB_BASE + RB_GPIO) begin
               m_rb[s] = {fp_in, db_in[s]};
            end else if (a == RB_DB_BASE + RB_MISC) begin
               m_rb[s] = {32'h0, m_misc_r[s]};
            end else begin
               m_rb[s] = '0;
            end
         end
         m_misc_r[s] = misc_in[s];
      end
   endtask

   // --------------------
   // stimulus and checks
   // --------------------
   task automatic drive_stimulus(input int phase);
      logic [7:0] addr;
      for (int s = 0; s < NUM_DBOARDS; s++) begin
         if (rand_bits(3) == 0) begin
            addr = 8'(rand_bits(8));
         end else begin
            addr = 8'(SR_DB_BASE - 4 + rand_bits(4));   // straddles the slot window
         end
         set_bus[s].stb  <= (rand_bits(2) != 0);
         set_bus[s].addr <= addr;
         set_bus[s].data <= rand_bits(32);
         rb_req[s].stb   <= (rand_bits(1) == 1);
         rb_req[s].addr  <= 8'(RB_DB_BASE + rand_bits(2));  // offsets 2 and 3 unmapped
         db_in[s]        <= rand_bits(32);
         misc_in[s]      <= rand_bits(32);
         blk_bank[s]     <= {rand_bits(32), rand_bits(32)};
         blk_ctr[s]      <= (phase >= 1) ? rand_bits(32) : '0;
      end
      if (rand_bits(2) == 0) begin   // flags hold for a few cycles
         rx_run <= NCH'(rand_bits(NCH));
         tx_run <= NCH'(rand_bits(NCH));
      end
      fp_in <= rand_bits(32);
      if (phase == 2) begin
         fp_src <= (2*FP_GPIO_WIDTH)'(rand_bits(2 * FP_GPIO_WIDTH));
      end
   endtask

   task automatic check_outputs();
      for (int s = 0; s < NUM_DBOARDS; s++) begin
         compare($sformatf("o_db_gpio[%0d].out", s), m_db_out[s], db_gpio[s].out);
         compare($sformatf("o_db_gpio[%0d].ddr", s), m_db_ddr[s], db_gpio[s].ddr);
         compare($sformatf("o_radio_led[%0d]", s), m_led[s], radio_led[s]);
         compare($sformatf("o_misc_out[%0d]", s), m_misc_out[s], misc_out[s]);
         compare($sformatf("o_rb_data[%0d]", s), m_rb[s], rb_data[s]);
      end
      compare("o_fp_gpio.out", m_fp_pin_out, fp_gpio.out);
      compare("o_fp_gpio.ddr", m_fp_pin_ddr, fp_gpio.ddr);
   endtask

   // negative phase keeps reset low and the inputs quiet
   task automatic run_cycle(input int phase);
      @(posedge radio_clk);
      model_edge();
      if (phase >= 0) begin
         rst_n <= 1'b1;
         drive_stimulus(phase);
      end
      @(negedge radio_clk);
      check_outputs();
   endtask

   initial begin
      lfsr   = 32'h7dbc;
      rst_n  = 1'b0;
      rx_run = '0;
      tx_run = '0;
      fp_in  = '0;
      fp_src = '0;
      for (int s = 0; s < NUM_DBOARDS; s++) begin
         set_bus[s]  = '0;
         rb_req[s]   = '0;
         db_in[s]    = '0;
         misc_in[s]  = '0;
         blk_ctr[s]  = '0;
         blk_bank[s] = '0;
      end
      model_reset();
      repeat (RESET_CYCLES) run_cycle(-1);   // model is all zero here
      for (int phase = 0; phase < 3; phase++) begin
         repeat (PHASE_CYCLES) run_cycle(phase);
      end
      $display("TEST OK");
      $finish;
   end

endmodule

`default_nettype wire

// File: radio_io_core.sv
// all inputs, the fp source word included, must already be in radio_clk; no synchronizers inside
`timescale 1ns/10ps
`default_nettype none

module radio_io_core
   import radio_io_pkg::*;
#(
   parameter int unsigned NUM_DBOARDS     = 2,
   parameter int unsigned CHANNELS_PER_DB = 2,
   parameter int unsigned FP_GPIO_WIDTH   = 12,
   parameter int unsigned SR_DB_BASE      = 160,
   parameter int unsigned RB_DB_BASE      = 16
) (
   input  wire                                     radio_clk,
   input  wire                                     i_rst_n,
   // per-slot buses
   input  wire set_bus_t                           i_set        [NUM_DBOARDS],
   input  wire rb_req_t                            i_rb         [NUM_DBOARDS],
   // channel activity, slot s owns bits s*CHANNELS_PER_DB and up
   input  wire [NUM_DBOARDS*CHANNELS_PER_DB-1:0]   i_rx_running,
   input  wire [NUM_DBOARDS*CHANNELS_PER_DB-1:0]   i_tx_running,
   // pin inputs
   input  wire gpio_word_t                         i_db_gpio_in [NUM_DBOARDS],
   input  wire gpio_word_t                         i_fp_gpio_in,
   input  wire gpio_word_t                         i_misc_in    [NUM_DBOARDS],
   // block control
   input  wire gpio_word_t                         i_blk_ctr    [NUM_DBOARDS],
   input  wire gpio_bank_t                         i_blk_bank   [NUM_DBOARDS],
   input  wire [2*FP_GPIO_WIDTH-1:0]               i_fp_gpio_src,
   // outputs
   output wire gpio_bank_t                         o_db_gpio    [NUM_DBOARDS],
   output wire gpio_bank_t                         o_fp_gpio,
   output wire [2:0]                               o_radio_led  [NUM_DBOARDS],
   output wire gpio_word_t                         o_misc_out   [NUM_DBOARDS],
   output wire rb_data_t                           o_rb_data    [NUM_DBOARDS]
);

   wire db_cfg_t    cfg         [NUM_DBOARDS];
   wire gpio_bank_t atr_bank    [NUM_DBOARDS];
   wire gpio_bank_t atr_fp_bank [NUM_DBOARDS];

   // --------------------
   // per-slot stages
   // --------------------
   for (genvar s = 0; s < NUM_DBOARDS; s++) begin : g_slot
      db_settings_regs #(
         .SR_DB_BASE (SR_DB_BASE),
         .RB_DB_BASE (RB_DB_BASE)
      ) db_settings_regs_inst (
         .radio_clk    (radio_clk),
         .i_rst_n      (i_rst_n),
         .i_set        (i_set[s]),
         .i_rb         (i_rb[s]),
         .i_db_gpio_in (i_db_gpio_in[s]),
         .i_fp_gpio_in (i_fp_gpio_in),      // every slot sees the whole front panel
         .i_misc_in    (i_misc_in[s]),
         .o_cfg        (cfg[s]),
         .o_misc_out   (o_misc_out[s]),
         .o_rb_data    (o_rb_data[s])
      );

      atr_gpio_select #(
         .CHANNELS_PER_DB (CHANNELS_PER_DB)
      ) atr_gpio_select_inst (
         .radio_clk    (radio_clk),
         .i_rst_n      (i_rst_n),
         .i_cfg        (cfg[s]),
         .i_rx_running (i_rx_running[s*CHANNELS_PER_DB +: CHANNELS_PER_DB]),
         .i_tx_running (i_tx_running[s*CHANNELS_PER_DB +: CHANNELS_PER_DB]),
         .o_bank       (atr_bank[s]),
         .o_fp_bank    (atr_fp_bank[s]),
         .o_led        (o_radio_led[s])
      );
   end

   // --------------------
   // shared pin mux
   // --------------------
   gpio_out_mux #(
      .NUM_DBOARDS   (NUM_DBOARDS),
      .FP_GPIO_WIDTH (FP_GPIO_WIDTH)
   ) gpio_out_mux_inst (
      .radio_clk     (radio_clk),
      .i_rst_n       (i_rst_n),
      .i_bank        (atr_bank),
      .i_fp_bank     (atr_fp_bank),
      .i_blk_ctr     (i_blk_ctr),
      .i_blk_bank    (i_blk_bank),
      .i_fp_gpio_src (i_fp_gpio_src),
      .o_db_gpio     (o_db_gpio),
      .o_fp_gpio     (o_fp_gpio)
   );

endmodule

`default_nettype wire

// File: gpio_out_mux.sv
// fp source fields above the last slot fall back to the last slot; fp pins past FP_GPIO_WIDTH stay 0
`timescale 1ns/10ps
`default_nettype none

module gpio_out_mux
   import radio_io_pkg::*;
#(
   parameter int unsigned NUM_DBOARDS   = 2,
   parameter int unsigned FP_GPIO_WIDTH = 12
) (
   input  wire                       radio_clk,
   input  wire                       i_rst_n,
   // ATR side, one entry per slot
   input  wire gpio_bank_t           i_bank     [NUM_DBOARDS],
   input  wire gpio_bank_t           i_fp_bank  [NUM_DBOARDS],
   // block side
   input  wire gpio_word_t           i_blk_ctr  [NUM_DBOARDS],  // 1 hands the pin to the block
   input  wire gpio_bank_t           i_blk_bank [NUM_DBOARDS],
   input  wire [2*FP_GPIO_WIDTH-1:0] i_fp_gpio_src,             // 2 bits per fp pin
   // pins
   output gpio_bank_t                o_db_gpio  [NUM_DBOARDS],
   output gpio_bank_t                o_fp_gpio
);

   gpio_bank_t db_next [NUM_DBOARDS];
   gpio_bank_t fp_next;

   // --------------------
   // block override
   // --------------------
   always_comb begin
      for (int s = 0; s < NUM_DBOARDS; s++) begin
         db_next[s].out = (i_blk_ctr[s] & i_blk_bank[s].out) | (~i_blk_ctr[s] & i_bank[s].out);
         db_next[s].ddr = (i_blk_ctr[s] & i_blk_bank[s].ddr) | (~i_blk_ctr[s] & i_bank[s].ddr);
      end
   end

   // --------------------
   // front-panel source
   // --------------------
   always_comb begin
      int unsigned sel;
      fp_next = '0;
      for (int p = 0; p < FP_GPIO_WIDTH; p++) begin
         sel = i_fp_gpio_src[2*p +: 2];
         if (sel >= NUM_DBOARDS) begin
            sel = NUM_DBOARDS - 1;   // no such slot
         end
         fp_next.out[p] = i_fp_bank[sel].out[p];
         fp_next.ddr[p] = i_fp_bank[sel].ddr[p];
      end
   end

   // pin registers, all inputs out of reset
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_db_gpio <= '{default: '0};
         o_fp_gpio <= '0;
      end else begin
         o_db_gpio <= db_next;
         o_fp_gpio <= fp_next;
      end
   end

endmodule

`default_nettype wire

// File: atr_gpio_select.sv
// all channels of a slot share one ATR state, so a single running channel moves the whole slot
`timescale 1ns/10ps
`default_nettype none

module atr_gpio_select
   import radio_io_pkg::*;
#(
   parameter int unsigned CHANNELS_PER_DB = 2
) (
   input  wire                       radio_clk,
   input  wire                       i_rst_n,
   input  wire db_cfg_t              i_cfg,
   input  wire [CHANNELS_PER_DB-1:0] i_rx_running,   // one flag per channel
   input  wire [CHANNELS_PER_DB-1:0] i_tx_running,
   output gpio_bank_t                o_bank,
   output gpio_bank_t                o_fp_bank,
   output logic [2:0]                o_led          // {rx, tx, rx only}
);

   atr_state_e state;
   logic       rx_act;
   logic       tx_act;

   // --------------------
   // ATR state
   // --------------------
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= IDLE;
      end else begin
         state <= atr_state_e'({|i_tx_running, |i_rx_running});
      end
   end

   assign rx_act = (state == RX) || (state == FDX);
   assign tx_act = (state == TX) || (state == FDX);

   // --------------------
   // gpio and LED select
   // --------------------
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_bank    <= '0;
         o_fp_bank <= '0;
         o_led     <= '0;
      end else begin
         unique case (state)
            IDLE : o_bank.out <= i_cfg.atr_idle;
            RX   : o_bank.out <= i_cfg.atr_rx;
            TX   : o_bank.out <= i_cfg.atr_tx;
            FDX  : o_bank.out <= i_cfg.atr_fdx;
         endcase
         o_bank.ddr <= i_cfg.ddr;      // direction does not follow ATR
         o_fp_bank  <= i_cfg.fp;
         // rx-only LED marks the TX/RX port listening
         o_led      <= {rx_act, tx_act, rx_act & ~tx_act};
      end
   end

   // every 2-bit code is a named state, so only an unknown flag can leave the legal set
   a_state_legal : assert property (
      @(posedge radio_clk) disable iff (!i_rst_n)
      !$isunknown(state)
   ) else $error("ATR state is unknown");

endmodule

`default_nettype wire

// File: db_settings_regs.sv
// one slot only; db and fp inputs are read back as they arrive, misc inputs pass one register first
`timescale 1ns/10ps
`default_nettype none

module db_settings_regs
   import radio_regmap_pkg::*;
   import radio_io_pkg::*;
#(
   parameter int unsigned SR_DB_BASE = 160,
   parameter int unsigned RB_DB_BASE = 16
) (
   input  wire             radio_clk,
   input  wire             i_rst_n,
   // settings and readback buses
   input  wire set_bus_t   i_set,
   input  wire rb_req_t    i_rb,
   // pins seen by readback
   input  wire gpio_word_t i_db_gpio_in,
   input  wire gpio_word_t i_fp_gpio_in,
   input  wire gpio_word_t i_misc_in,
   // register file contents
   output db_cfg_t         o_cfg,
   output gpio_word_t      o_misc_out,
   output rb_data_t        o_rb_data
);

   sr_addr_t   sr_off;      // write address relative to this slot
   sr_addr_t   rb_off;      // readback address relative to this slot
   gpio_word_t misc_in_r;

   assign sr_off = i_set.addr - sr_addr_t'(SR_DB_BASE);
   assign rb_off = i_rb.addr - sr_addr_t'(RB_DB_BASE);

   // --------------------
   // settings writes
   // --------------------
   // addresses below the base wrap to large offsets, so they miss as well
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_cfg      <= '0;
         o_misc_out <= '0;
      end else if (i_set.stb) begin
         case (sr_off)
            ATR_IDLE : o_cfg.atr_idle <= i_set.data;
            ATR_RX   : o_cfg.atr_rx   <= i_set.data;
            ATR_TX   : o_cfg.atr_tx   <= i_set.data;
            ATR_FDX  : o_cfg.atr_fdx  <= i_set.data;
            GPIO_DDR : o_cfg.ddr      <= i_set.data;
            MISC_OUT : o_misc_out     <= i_set.data;  // goes straight to the pins
            FP_OUT   : o_cfg.fp.out   <= i_set.data;
            FP_DDR   : o_cfg.fp.ddr   <= i_set.data;
            default  : ;                               // not this slot
         endcase
      end
   end

   // --------------------
   // misc input capture
   // --------------------
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         misc_in_r <= '0;
      end else begin
         misc_in_r <= i_misc_in;
      end
   end

   // --------------------
   // readback
   // --------------------
   // o_rb_data holds the last answer until the next request
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_rb_data <= '0;
      end else if (i_rb.stb) begin
         case (rb_off)
            RB_GPIO : o_rb_data <= {i_fp_gpio_in, i_db_gpio_in};
            RB_MISC : o_rb_data <= {{GPIO_W{1'b0}}, misc_in_r};
            default : o_rb_data <= '0;
         endcase
      end
   end

   // an unknown strobe from the bus master would smear X over the whole register file
   a_set_stb_known : assert property (
      @(posedge radio_clk) disable iff (!i_rst_n)
      !$isunknown(i_set.stb)
   ) else $error("settings strobe is unknown");

endmodule

`default_nettype wire

// File: radio_io_pkg.sv
// gpio words are 32 bits wide; a ddr bit of 1 makes the pin an output, 0 leaves it an input
`default_nettype none

package radio_io_pkg;
   import radio_regmap_pkg::*;

   typedef logic [GPIO_W-1:0]    gpio_word_t;
   typedef logic [RB_DATA_W-1:0] rb_data_t;

   // one set of pins, value and direction side by side
   typedef struct packed {
      gpio_word_t out;
      gpio_word_t ddr;
   } gpio_bank_t;

   // --------------------
   // slot buses
   // --------------------
   typedef struct packed {
      logic       stb;    // single-cycle write strobe
      sr_addr_t   addr;
      gpio_word_t data;
   } set_bus_t;

   typedef struct packed {
      logic     stb;      // samples the readback mux
      sr_addr_t addr;
   } rb_req_t;

   // everything the settings registers hand to the ATR stage
   typedef struct packed {
      gpio_word_t atr_idle;
      gpio_word_t atr_rx;
      gpio_word_t atr_tx;
      gpio_word_t atr_fdx;
      gpio_word_t ddr;
      gpio_bank_t fp;
   } db_cfg_t;

   // bit 1 is tx running, bit 0 is rx running
   typedef enum logic [1:0] {
      IDLE = 2'b00,
      RX   = 2'b01,
      TX   = 2'b10,
      FDX  = 2'b11
   } atr_state_e;

endpackage

`default_nettype wire

// File: radio_regmap_pkg.sv
// settings offsets count from SR_DB_BASE and readback offsets from RB_DB_BASE, one window per slot
`default_nettype none

package radio_regmap_pkg;

   // --------------------
   // bus field widths
   // --------------------
   localparam int SR_ADDR_W = 8;    // settings and readback address
   localparam int GPIO_W    = 32;   // one settings data word
   localparam int RB_DATA_W = 64;   // one readback word

   typedef logic [SR_ADDR_W-1:0] sr_addr_t;

   // --------------------
   // settings map
   // --------------------
   // offsets use the full address width, so anything past the slot window
   // simply matches no entry and is dropped by the decoder
   typedef enum logic [SR_ADDR_W-1:0] {
      ATR_IDLE = 8'd0,  // gpio out while no channel runs
      ATR_RX   = 8'd1,  // gpio out while receiving only
      ATR_TX   = 8'd2,  // gpio out while transmitting only
      ATR_FDX  = 8'd3,  // gpio out in full duplex
      GPIO_DDR = 8'd4,  // db pin direction, 1 drives
      MISC_OUT = 8'd5,
      FP_OUT   = 8'd6,  // this slot's front-panel request
      FP_DDR   = 8'd7
   } sr_offset_e;

   // --------------------
   // readback map
   // --------------------
   typedef enum logic [SR_ADDR_W-1:0] {
      RB_GPIO = 8'd0,   // {fp in, db in}
      RB_MISC = 8'd1    // {zero, captured misc in}
   } rb_offset_e;

endpackage

`default_nettype wire
